// File: Makefile
# Verilator build and run for the job assignment search

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module tb_jam \
		-Mdir $(OBJ_DIR) -o tb_jam

# exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/tb_jam

clean:
	rm -rf $(OBJ_DIR)

// File: design/cost_scanner.sv
// cost scanner: walks the workers of one permutation and sums their costs
`include "jam_consts.svh"

module cost_scanner (
	input  logic            CLK,
	input  logic            RST,
	input  logic            running,
	input  jam_pkg::perm_t  perm,
	input  jam_pkg::cost_t  Cost,
	output jam_pkg::idx_t   W,
	output jam_pkg::idx_t   J,
	output logic            scan_end,
	output jam_pkg::total_t total
);
	import jam_pkg::*;

	total_t psum;
	logic   last_worker;

	assign last_worker = W == idx_t'(`JAM_N - 1);

	// table lookup is combinational, so J and Cost line up in one cycle
	assign J = perm[W];

	// complete sum shows up together with the last worker
	assign total    = psum + total_t'(Cost);
	assign scan_end = running && last_worker;

	////////////////////////////////////////////////////////////
	// worker index
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (RST) begin
			W <= '0;
		end else if (!running) begin
			W <= '0;
		end else begin
			// wraps 7 -> 0 into the next permutation
			W <= W + idx_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// partial sum
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!running || last_worker)
			psum <= '0;
		else
			psum <= total;
	end

endmodule

// File: design/jam_consts.svh
// job assignment constants: problem size and datapath widths
`ifndef JAM_CONSTS_SVH
`define JAM_CONSTS_SVH

// eight workers, eight jobs
`define JAM_N 8

// worker or job index
`define JAM_IDX_W 3

// one cost table entry
`define JAM_COST_W 7

// 8 x 127 = 1016 still fits
`define JAM_TOTAL_W 10

// wide enough for all 8! ties
`define JAM_MATCH_W 16

`endif

// File: design/jam_ctrl.sv
// run controller: four-phase req/ack around one full permutation sweep
module jam_ctrl (
	input  logic CLK,
	input  logic RST,
	input  logic req,
	input  logic is_last,
	input  logic scan_end,
	output logic start,
	output logic running,
	output logic ack
);
	import jam_pkg::*;

	ctrl_state_e state;

	// scanner and generator are live only in RUN
	assign running = state == RUN;

	always_ff @(posedge CLK) begin
		if (RST) begin
			state <= IDLE;
			start <= 1'b0;
			ack   <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				IDLE: begin
					if (req) begin
						state <= RUN;
						start <= 1'b1;
					end
				end
				RUN: begin
					// final scan of the descending permutation
					if (scan_end && is_last)
						state <= DONE;
				end
				DONE: begin
					// first cycle here lets min_tracker take the last total
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack   <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/jam_pkg.sv
// job assignment types shared by the datapath and the controller
`include "jam_consts.svh"

package jam_pkg;

	typedef logic [`JAM_IDX_W-1:0] idx_t;
	typedef logic [`JAM_COST_W-1:0] cost_t;
	typedef logic [`JAM_TOTAL_W-1:0] total_t;
	typedef logic [`JAM_MATCH_W-1:0] match_t;

	// entry w holds the job given to worker w
	typedef idx_t perm_t [`JAM_N];

	// run control for the req/ack handshake
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} ctrl_state_e;

endpackage

// File: design/jam_top.sv
// job assignment top: exhaustive permutation search for the cheapest assignment
module jam_top (
	input  logic            CLK,
	input  logic            RST,
	input  logic            req,
	output logic            ack,
	output jam_pkg::idx_t   W,
	output jam_pkg::idx_t   J,
	input  jam_pkg::cost_t  Cost,
	output jam_pkg::total_t MinCost,
	output jam_pkg::match_t MatchCount
);
	import jam_pkg::*;

	logic   start;
	logic   running;
	logic   scan_end;
	total_t total;
	perm_t  perm;
	logic   is_last;
	logic   next_ready;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	jam_ctrl jam_ctrl_inst (
		.CLK      (CLK),
		.RST      (RST),
		.req      (req),
		.is_last  (is_last),
		.scan_end (scan_end),
		.start    (start),
		.running  (running),
		.ack      (ack)
	);

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	// costs the current permutation one worker per cycle
	cost_scanner cost_scanner_inst (
		.CLK      (CLK),
		.RST      (RST),
		.running  (running),
		.perm     (perm),
		.Cost     (Cost),
		.W        (W),
		.J        (J),
		.scan_end (scan_end),
		.total    (total)
	);

	// successor is prepared while the scanner works
	perm_gen perm_gen_inst (
		.CLK        (CLK),
		.RST        (RST),
		.start      (start),
		.scan_end   (scan_end),
		.perm       (perm),
		.is_last    (is_last),
		.next_ready (next_ready)
	);

	min_tracker min_tracker_inst (
		.CLK        (CLK),
		.RST        (RST),
		.start      (start),
		.scan_end   (scan_end),
		.total      (total),
		.MinCost    (MinCost),
		.MatchCount (MatchCount)
	);

endmodule

// File: design/min_tracker.sv
// minimum tracker: running minimum of assignment totals and its tie count
module min_tracker (
	input  logic            CLK,
	input  logic            RST,
	input  logic            start,
	input  logic            scan_end,
	input  jam_pkg::total_t total,
	output jam_pkg::total_t MinCost,
	output jam_pkg::match_t MatchCount
);
	import jam_pkg::*;

	always_ff @(posedge CLK) begin
		if (RST) begin
			MinCost    <= '1;
			MatchCount <= '0;
		end else if (start) begin
			// fresh run, nothing carried over
			MinCost    <= '1;
			MatchCount <= '0;
		end else if (scan_end) begin
			if (total < MinCost) begin
				MinCost    <= total;
				MatchCount <= match_t'(1);
			end else if (total == MinCost) begin
				MatchCount <= MatchCount + match_t'(1);
			end
		end
	end

endmodule

// File: design/perm_gen.sv
// permutation generator: lexicographic successor built behind the current scan
`include "jam_consts.svh"

module perm_gen (
	input  logic           CLK,
	input  logic           RST,
	input  logic           start,
	input  logic           scan_end,
	output jam_pkg::perm_t perm,
	output logic           is_last,
	output logic           next_ready
);
	import jam_pkg::*;

	typedef enum logic [1:0] {
		PG_IDLE,
		PG_FIND,
		PG_SEARCH,
		PG_READY
	} pg_state_e;

	pg_state_e state;
	perm_t     perm_next;
	idx_t      pivot_c;
	logic      pivot_found;
	idx_t      pivot_q;
	idx_t      succ_q;
	idx_t      pos_q;
	idx_t      pivot_val;
	idx_t      cand_val;
	idx_t      best_val;
	logic      find_en;

	function automatic perm_t ascending();
		perm_t p;
		for (int i = 0; i < `JAM_N; i++) begin
			p[i] = idx_t'(i);
		end
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// pivot: rightmost position below its right neighbour
	////////////////////////////////////////////////////////////

	always_comb begin
		pivot_found = 1'b0;
		pivot_c     = '0;
		for (int i = 0; i < `JAM_N - 1; i++) begin
			if (perm[i] < perm[i + 1]) begin
				pivot_found = 1'b1;
				pivot_c     = idx_t'(i);
			end
		end
	end

	// perm already sits at the ascending start when start arrives
	assign find_en   = start || state == PG_FIND;
	assign pivot_val = perm[pivot_q];
	assign cand_val  = perm[pos_q];
	assign best_val  = perm[succ_q];

	assign next_ready = state == PG_READY;

	perm_reorder perm_reorder_inst (
		.perm_in  (perm),
		.pivot    (pivot_q),
		.succ     (succ_q),
		.perm_out (perm_next)
	);

	always_ff @(posedge CLK) begin
		if (RST) begin
			state   <= PG_IDLE;
			is_last <= 1'b0;
			perm    <= ascending();
		end else if (find_en) begin
			if (start)
				perm <= ascending();
			// right neighbour is a known candidate, search starts one further
			pivot_q <= pivot_c;
			succ_q  <= pivot_c + idx_t'(1);
			pos_q   <= pivot_c + idx_t'(2);
			is_last <= !pivot_found;
			if (!pivot_found || pivot_c == idx_t'(`JAM_N - 2))
				state <= PG_READY;
			else
				state <= PG_SEARCH;
		end else begin
			case (state)
				PG_SEARCH: begin
					// smallest tail entry above the pivot entry
					if (cand_val > pivot_val && cand_val < best_val)
						succ_q <= pos_q;
					if (pos_q == idx_t'(`JAM_N - 1))
						state <= PG_READY;
					else
						pos_q <= pos_q + idx_t'(1);
				end
				PG_READY: begin
					if (scan_end && is_last) begin
						// park at the first permutation for the next run
						perm    <= ascending();
						is_last <= 1'b0;
						state   <= PG_IDLE;
					end else if (scan_end) begin
						perm  <= perm_next;
						state <= PG_FIND;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: design/perm_reorder.sv
// permutation reorder: swap pivot with successor, then reverse the tail
`include "jam_consts.svh"

module perm_reorder (
	input  jam_pkg::perm_t perm_in,
	input  jam_pkg::idx_t  pivot,
	input  jam_pkg::idx_t  succ,
	output jam_pkg::perm_t perm_out
);
	import jam_pkg::*;

	perm_t swapped;

	////////////////////////////////////////////////////////////
	// swap
	////////////////////////////////////////////////////////////

	always_comb begin
		swapped        = perm_in;
		swapped[pivot] = perm_in[succ];
		swapped[succ]  = perm_in[pivot];
	end

	////////////////////////////////////////////////////////////
	// tail reversal
	////////////////////////////////////////////////////////////

	// tail is descending after the swap, reversing it makes it ascending
	always_comb begin
		idx_t mirror;
		for (int k = 0; k < `JAM_N; k++) begin
			mirror = idx_t'(`JAM_N + int'(pivot) - k);
			if (k > int'(pivot))
				perm_out[k] = swapped[mirror];
			else
				perm_out[k] = swapped[k];
		end
	end

endmodule

// File: files.f
+incdir+design
design/jam_pkg.sv
design/jam_ctrl.sv
design/cost_scanner.sv
design/perm_reorder.sv
design/perm_gen.sv
design/min_tracker.sv
design/jam_top.sv
test/jam_assert.sv
test/tb_jam.sv

// File: test/jam_assert.sv
// handshake and scan assertions bound to the job assignment top level
`include "jam_consts.svh"

module jam_assert (
	input logic            CLK,
	input logic            RST,
	input logic            req,
	input logic            ack,
	input logic            running,
	input logic            scan_end,
	input logic            next_ready,
	input jam_pkg::idx_t   W,
	input jam_pkg::idx_t   J,
	input jam_pkg::total_t MinCost,
	input jam_pkg::match_t MatchCount
);
	timeunit 1ns;
	timeprecision 100ps;

	import jam_pkg::*;

	logic              seen_req;
	logic [`JAM_N-1:0] jobs_seen;
	logic [`JAM_N-1:0] job_bit;

	assign job_bit = {{(`JAM_N - 1){1'b0}}, 1'b1} << J;

	// jobs already handed out earlier in the current scan
	always_ff @(posedge CLK) begin
		if (RST) begin
			seen_req  <= 1'b0;
			jobs_seen <= '0;
		end else begin
			if (req)
				seen_req <= 1'b1;
			if (running && W == '0)
				jobs_seen <= job_bit;
			else if (running)
				jobs_seen <= jobs_seen | job_bit;
		end
	end

	////////////////////////////////////////////////////////////
	// req/ack handshake
	////////////////////////////////////////////////////////////

	ack_quiet_after_reset: assert property (@(posedge CLK) disable iff (RST)
		!seen_req |-> !ack)
		else $error("ack went high before the first req");

	ack_rise_with_req: assert property (@(posedge CLK) disable iff (RST)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	ack_held_by_req: assert property (@(posedge CLK) disable iff (RST)
		ack && req |=> ack)
		else $error("ack dropped while req was still high");

	ack_released: assert property (@(posedge CLK) disable iff (RST)
		ack && !req |=> !ack)
		else $error("ack stayed high after req fell");

	result_steady: assert property (@(posedge CLK) disable iff (RST)
		ack && $past(ack) |-> $stable(MinCost) && $stable(MatchCount))
		else $error("result moved while ack was high");

	////////////////////////////////////////////////////////////
	// worker scan
	////////////////////////////////////////////////////////////

	scan_starts_at_zero: assert property (@(posedge CLK) disable iff (RST)
		$rose(running) |-> W == '0)
		else $error("scan did not start at worker zero");

	scan_steps_by_one: assert property (@(posedge CLK) disable iff (RST)
		running && $past(running) |-> W == $past(W) + idx_t'(1))
		else $error("worker index skipped or stalled");

	// eight workers get eight different jobs
	jobs_unique: assert property (@(posedge CLK) disable iff (RST)
		running && W != '0 |-> !jobs_seen[J])
		else $error("one job was given to two workers in a scan");

	// successor is prepared before the current scan ends
	successor_in_time: assert property (@(posedge CLK) disable iff (RST)
		scan_end |-> next_ready)
		else $error("next permutation was not ready at the end of a scan");

endmodule

bind jam_top jam_assert jam_assert_inst (
	.CLK        (CLK),
	.RST        (RST),
	.req        (req),
	.ack        (ack),
	.running    (running),
	.scan_end   (scan_end),
	.next_ready (next_ready),
	.W          (W),
	.J          (J),
	.MinCost    (MinCost),
	.MatchCount (MatchCount)
);

// File: test/tb_jam.sv
// testbench for the job assignment search with cost tables, reference sweep and req/ack runs
`include "jam_consts.svh"

module tb_jam;
	timeunit 1ns;
	timeprecision 100ps;

	import jam_pkg::*;

	localparam int PERM_COUNT     = 40320;
	localparam int RUN_COUNT      = 3;
	localparam int SCAN_CYCLES    = PERM_COUNT * `JAM_N;
	// three full sweeps plus room for handshake overhead
	localparam int TIMEOUT_CYCLES = RUN_COUNT * SCAN_CYCLES + 32320;

	logic    CLK;
	logic    RST;
	logic    req;
	logic    ack;
	idx_t    W;
	idx_t    J;
	cost_t   Cost;
	total_t  MinCost;
	match_t  MatchCount;

	cost_t       cost_table [`JAM_N][`JAM_N];
	total_t      exp_min;
	match_t      exp_count;
	logic [15:0] lfsr_state;
	int          cycle_count = 0;

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// table read by worker and job in the same cycle
	assign Cost = cost_table[W][J];

	jam_top jam_top_inst (
		.CLK        (CLK),
		.RST        (RST),
		.req        (req),
		.ack        (ack),
		.W          (W),
		.J          (J),
		.Cost       (Cost),
		.MinCost    (MinCost),
		.MatchCount (MatchCount)
	);

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// cost tables
	////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic fill_random_table();
		cost_t c;
		for (int w = 0; w < `JAM_N; w++) begin
			for (int j = 0; j < `JAM_N; j++) begin
				c = '0;
				repeat (`JAM_COST_W) begin
					lfsr_state = lfsr_next(lfsr_state);
					c = {c[`JAM_COST_W-2:0], lfsr_state[0]};
				end
				cost_table[w][j] = c;
			end
		end
	endtask

	// diagonal 1..8 with every other entry far above any diagonal sum
	task automatic fill_diagonal_table();
		int diag_sum;
		diag_sum = 0;
		for (int w = 0; w < `JAM_N; w++) begin
			for (int j = 0; j < `JAM_N; j++) begin
				cost_table[w][j] = (w == j) ? cost_t'(w + 1) : cost_t'(100);
			end
			diag_sum += w + 1;
		end
		exp_min   = total_t'(diag_sum);
		exp_count = match_t'(1);
	endtask

	task automatic fill_uniform_table(input cost_t value);
		for (int w = 0; w < `JAM_N; w++) begin
			for (int j = 0; j < `JAM_N; j++) begin
				cost_table[w][j] = value;
			end
		end
		exp_min   = total_t'(int'(value) * `JAM_N);
		exp_count = match_t'(PERM_COUNT);
	endtask

	////////////////////////////////////////////////////////////
	// reference sweep
	////////////////////////////////////////////////////////////

	// every assignment in lexicographic order from the ascending one
	task automatic compute_reference(output total_t min_v, output match_t count_v);
		int p [`JAM_N];
		int sum;
		int best;
		int ties;
		int pivot;
		int succ;
		int tmp;
		int lo;
		int hi;
		bit more;
		for (int i = 0; i < `JAM_N; i++)
			p[i] = i;
		best = 1 << 30;
		ties = 0;
		more = 1'b1;
		while (more) begin
			sum = 0;
			for (int w = 0; w < `JAM_N; w++)
				sum += int'(cost_table[w][p[w]]);
			if (sum < best) begin
				best = sum;
				ties = 1;
			end else if (sum == best) begin
				ties++;
			end
			pivot = -1;
			for (int i = `JAM_N - 2; i >= 0 && pivot < 0; i--)
				if (p[i] < p[i + 1])
					pivot = i;
			if (pivot < 0) begin
				more = 1'b0;
			end else begin
				// tail is descending, so the rightmost larger entry is the smallest larger
				succ = `JAM_N - 1;
				while (p[succ] <= p[pivot])
					succ--;
				tmp      = p[pivot];
				p[pivot] = p[succ];
				p[succ]  = tmp;
				lo = pivot + 1;
				hi = `JAM_N - 1;
				while (lo < hi) begin
					tmp   = p[lo];
					p[lo] = p[hi];
					p[hi] = tmp;
					lo++;
					hi--;
				end
			end
		end
		min_v   = total_t'(best);
		count_v = match_t'(ties);
	endtask

	////////////////////////////////////////////////////////////
	// handshake and result checks
	////////////////////////////////////////////////////////////

	task automatic run_search();
		@(posedge CLK);
		req <= 1'b1;
		while (!ack)
			@(posedge CLK);
		// keep req up a while so the held result gets looked at
		repeat (3) @(posedge CLK);
		req <= 1'b0;
		while (ack)
			@(posedge CLK);
	endtask

	result_min: assert property (@(posedge CLK) disable iff (RST)
		$rose(ack) |-> MinCost == exp_min)
		else stop_on_error($sformatf("Fail MinCost expected %h actual %h",
			exp_min, $sampled(MinCost)));

	result_count: assert property (@(posedge CLK) disable iff (RST)
		$rose(ack) |-> MatchCount == exp_count)
		else stop_on_error($sformatf("Fail MatchCount expected %h actual %h",
			exp_count, $sampled(MatchCount)));

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("ack never arrived within %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		RST        = 1'b1;
		req        = 1'b0;
		lfsr_state = 16'd3175;
		fill_uniform_table(cost_t'(0));
		repeat (2) @(posedge CLK);
		RST <= 1'b0;
		// a few idle cycles with ack expected low
		repeat (4) @(posedge CLK);

		fill_random_table();
		compute_reference(exp_min, exp_count);
		run_search();

		fill_diagonal_table();
		run_search();

		// larger minimum than before, so leftovers from the last run would show
		fill_uniform_table(cost_t'(37));
		run_search();

		$display("test passed");
		$finish;
	end

endmodule
